// ==== mini_dsp.f ====
dsp_isa_pkg.sv
dsp_dau_pkg.sv
dsp_ctrl.sv
dsp_rom.sv
dsp_rom_aau.sv
dsp_ram_aau.sv
dsp_ram.sv
dsp_dau.sv
dsp_pio.sv
mini_dsp.sv
tb_mini_dsp.sv

// ==== tb_mini_dsp.sv ====
// Table-driven testbench for the DSP core with ROM loading, program runs and output checks
module tb_mini_dsp;
    import dsp_isa_pkg::*;

    localparam int ROM_AW     = 8;
    localparam int RAM_AW     = 6;
    localparam int NROWS      = 6;
    localparam int PROG_WORDS = 16;
    localparam int MAX_OUT    = 4;
    localparam int MAX_INSTR  = 64;
    localparam int RST_CYCLES = 8;
    localparam int POST_HALT  = 8;
    localparam int WATCHDOG_CYCLES = NROWS * (2 * PROG_WORDS + 2 * MAX_INSTR + 20);
    // Highest RAM word, used to exercise pointer wrap
    localparam logic [9:0] TOP_ADDR = 10'(2**RAM_AW - 1);

    logic              clk;
    logic              arst_n;
    logic              cen;
    logic [ROM_AW:0]   prog_addr;
    logic [7:0]        prog_data;
    logic              prog_we;
    logic [15:0]       pbus_in;
    logic [15:0]       pbus_out;
    logic              pods_n;
    logic              pids_n;
    logic              halted;

    // Stimulus and expected results, one row per test
    string       row_name    [NROWS];
    logic [15:0] row_prog    [NROWS][PROG_WORDS];
    logic [15:0] row_pbus_in [NROWS];
    logic [15:0] row_exp     [NROWS][MAX_OUT];
    int          row_n_out   [NROWS];
    int          row_n_pids  [NROWS];

    int     errors;
    int     checks;
    integer seed;

    mini_dsp #(
        .ROM_AW ( ROM_AW ),
        .RAM_AW ( RAM_AW )
    ) u_dut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cen       ( cen       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .pbus_in   ( pbus_in   ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .pids_n    ( pids_n    ),
        .halted    ( halted    )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [15:0] make_instr(opcode_t op, logic [11:0] opnd);
        return {op, opnd};
    endfunction

    // LDP operand with the pointer number in the top two bits
    function automatic logic [11:0] ldp_operand(logic [1:0] sel, logic [9:0] addr);
        return {sel, addr};
    endfunction

    task automatic put_instr(int r, int idx, opcode_t op, logic [11:0] opnd);
        row_prog[r][idx] = make_instr(op, opnd);
    endtask

    task automatic expect_word(int r, logic [15:0] value);
        row_exp[r][row_n_out[r]] = value;
        row_n_out[r]++;
    endtask

    task automatic build_table();
        integer             rnd;
        logic [11:0]        ra;
        logic [11:0]        rb;
        logic signed [15:0] a16;
        logic signed [15:0] b16;
        logic signed [31:0] prod;
        for (int r = 0; r < NROWS; r++) begin
            for (int w = 0; w < PROG_WORDS; w++) begin
                row_prog[r][w] = make_instr(HALT, 12'h000);
            end
            row_pbus_in[r] = 16'h0000;
            row_n_out[r]   = 0;
            row_n_pids[r]  = 0;
        end

        // Largest by most negative immediate, 2047 * -2048
        row_name[0] = "mpy_imm";
        put_instr(0, 0, LDX, 12'h7FF);
        put_instr(0, 1, LDY, 12'h800);
        put_instr(0, 2, MPY, 12'h000);
        put_instr(0, 3, OUT, 12'h000);
        put_instr(0, 4, OUT, 12'h001);
        expect_word(0, 16'h0800);
        expect_word(0, 16'hFFC0);

        row_name[1] = "mpy_rand";
        rnd = $random(seed);
        ra  = rnd[11:0];
        rnd = $random(seed);
        rb  = rnd[11:0];
        a16 = {{4{ra[11]}}, ra};
        b16 = {{4{rb[11]}}, rb};
        prod = a16 * b16;
        put_instr(1, 0, LDX, ra);
        put_instr(1, 1, LDY, rb);
        put_instr(1, 2, MPY, 12'h000);
        put_instr(1, 3, OUT, 12'h000);
        put_instr(1, 4, OUT, 12'h001);
        expect_word(1, prod[15:0]);
        expect_word(1, prod[31:16]);

        // Three passes of MAC and OUT, 7 * 9 added each time
        row_name[2] = "mac_loop";
        put_instr(2, 0, CLRA, 12'h000);
        put_instr(2, 1, LDX, 12'd7);
        put_instr(2, 2, LDY, 12'd9);
        put_instr(2, 3, LDC, 12'd3);
        put_instr(2, 4, MAC, 12'h000);
        put_instr(2, 5, OUT, 12'h000);
        put_instr(2, 6, DJNZ, 12'd4);
        expect_word(2, 16'd63);
        expect_word(2, 16'd126);
        expect_word(2, 16'd189);

        // Store at the top word and at word 0 through one pointer, read back through another
        row_name[3] = "ram_wrap";
        put_instr(3, 0, LDX, 12'd5);
        put_instr(3, 1, LDY, 12'd1);
        put_instr(3, 2, MPY, 12'h000);
        put_instr(3, 3, LDP, ldp_operand(2'd1, TOP_ADDR));
        put_instr(3, 4, WRA, 12'h001);
        put_instr(3, 5, LDX, 12'd6);
        put_instr(3, 6, MPY, 12'h000);
        put_instr(3, 7, WRA, 12'h001);
        put_instr(3, 8, LDP, ldp_operand(2'd2, TOP_ADDR));
        put_instr(3, 9, RDX, 12'h002);
        put_instr(3, 10, MPY, 12'h000);
        put_instr(3, 11, OUT, 12'h000);
        put_instr(3, 12, RDX, 12'h002);
        put_instr(3, 13, MPY, 12'h000);
        put_instr(3, 14, OUT, 12'h000);
        expect_word(3, 16'd5);
        expect_word(3, 16'd6);

        // Opcode 15 and NOP first, then the input word echoed back
        row_name[4] = "inp_echo";
        row_pbus_in[4] = 16'hA5C3;
        row_n_pids[4]  = 1;
        put_instr(4, 0, NOP, 12'h000);
        row_prog[4][1] = 16'hF123;
        put_instr(4, 2, INP, 12'h000);
        put_instr(4, 3, LDY, 12'd1);
        put_instr(4, 4, MPY, 12'h000);
        put_instr(4, 5, OUT, 12'h000);
        put_instr(4, 6, OUT, 12'h001);
        expect_word(4, 16'hA5C3);
        expect_word(4, 16'hFFFF);

        // A taken GOTO hides the first product
        row_name[5] = "goto_halt";
        put_instr(5, 0, LDX, 12'd2);
        put_instr(5, 1, LDY, 12'd3);
        put_instr(5, 2, MPY, 12'h000);
        put_instr(5, 3, GOTO, 12'd5);
        put_instr(5, 4, OUT, 12'h000);
        put_instr(5, 5, LDX, 12'd4);
        put_instr(5, 6, MPY, 12'h000);
        put_instr(5, 7, OUT, 12'h000);
        put_instr(5, 8, HALT, 12'h000);
        put_instr(5, 9, OUT, 12'h000);
        expect_word(5, 16'd12);
    endtask

    task automatic load_program(int r);
        for (int w = 0; w < PROG_WORDS; w++) begin
            for (int b = 0; b < 2; b++) begin
                @(negedge clk);
                prog_we   = 1'b1;
                prog_addr = (ROM_AW+1)'(2 * w + b);
                prog_data = (b == 0) ? row_prog[r][w][7:0] : row_prog[r][w][15:8];
            end
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic reset_core(int r);
        arst_n  = 1'b0;
        pbus_in = row_pbus_in[r];
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        checks++;
        if (pods_n !== 1'b1 || pids_n !== 1'b1 || halted !== 1'b0) begin
            $display("ERROR %s: strobes not idle or halted set after reset", row_name[r]);
            errors++;
        end
    endtask

    task automatic run_row(int r);
        logic [15:0] seen [$];
        int          n_pids;
        int          cycles;
        int          late_out;
        int          lost_halt;
        n_pids    = 0;
        cycles    = 0;
        late_out  = 0;
        lost_halt = 0;
        cen = 1'b1;
        while (halted !== 1'b1 && cycles < 2 * MAX_INSTR) begin
            @(negedge clk);
            cycles++;
            if (pods_n === 1'b0) begin
                seen.push_back(pbus_out);
            end
            if (pids_n === 1'b0) begin
                n_pids++;
            end
        end
        checks++;
        if (halted !== 1'b1) begin
            $display("ERROR %s: core did not halt within %0d cycles", row_name[r], cycles);
            errors++;
        end
        // Core must stay quiet once halted
        repeat (POST_HALT) begin
            @(negedge clk);
            if (pods_n === 1'b0 || pids_n === 1'b0) begin
                late_out++;
            end
            if (halted !== 1'b1) begin
                lost_halt++;
            end
        end
        cen = 1'b0;
        checks++;
        if (late_out != 0 || lost_halt != 0) begin
            $display("ERROR %s: port strobes after HALT or halted flag dropped", row_name[r]);
            errors++;
        end
        for (int i = 0; i < row_n_out[r] && i < seen.size(); i++) begin
            checks++;
            if (seen[i] !== row_exp[r][i]) begin
                $display("MISMATCH %s word %0d: expected %h, actual %h",
                         row_name[r], i, row_exp[r][i], seen[i]);
                errors++;
            end
        end
        checks++;
        if (seen.size() != row_n_out[r]) begin
            $display("ERROR %s: %0d output words seen, %0d expected",
                     row_name[r], seen.size(), row_n_out[r]);
            errors++;
        end
        checks++;
        if (n_pids != row_n_pids[r]) begin
            $display("ERROR %s: pids_n pulsed %0d times, %0d expected",
                     row_name[r], n_pids, row_n_pids[r]);
            errors++;
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        cen       = 1'b0;
        prog_addr = '0;
        prog_data = 8'h00;
        prog_we   = 1'b0;
        pbus_in   = 16'h0000;
        errors    = 0;
        checks    = 0;
        seed      = 32'h8850_205d;
        build_table();
        for (int r = 0; r < NROWS; r++) begin
            load_program(r);
            reset_core(r);
            run_row(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== mini_dsp.sv ====
// Core top level joining sequencer, memories, address units, arithmetic and port
module mini_dsp #(
    parameter int ROM_AW = 8,
    parameter int RAM_AW = 6
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           cen,
    // ROM programming
    input  logic [ROM_AW:0]                prog_addr,
    input  logic [7:0]                     prog_data,
    input  logic                           prog_we,
    // Parallel I/O
    input  logic [dsp_dau_pkg::DATA_W-1:0] pbus_in,
    output logic [dsp_dau_pkg::DATA_W-1:0] pbus_out,
    output logic                           pods_n,
    output logic                           pids_n,
    output logic                           halted
);
    import dsp_isa_pkg::*;
    import dsp_dau_pkg::*;

    logic [INSTR_W-1:0]   instr;
    logic [OPND_W-1:0]    operand;
    logic [ROM_AW-1:0]    pc;
    logic                 pc_inc, jump, cnt_load, djnz, halt_set;
    // RAM side
    logic                 ptr_load, ptr_post, ram_we;
    logic [PTR_SEL_W-1:0] ptr_sel;
    logic [RAM_AW-1:0]    ram_addr;
    logic [DATA_W-1:0]    ram_dout;
    // Arithmetic side
    logic                 x_imm_load, y_imm_load, x_ram_load, x_pio_load;
    logic                 mpy, mac, acc_clr;
    logic [DATA_W-1:0]    acc_dout;
    logic [ACC_W-1:0]     acc_full;
    // Parallel port
    logic                 out_strobe, in_strobe;
    out_half_t            out_half;
    logic [DATA_W-1:0]    pio_din;

    dsp_ctrl u_ctrl (.*);

    dsp_rom #(.ROM_AW(ROM_AW)) u_rom (.*);

    dsp_rom_aau #(.ROM_AW(ROM_AW)) u_rom_aau (.*);

    dsp_ram_aau #(.RAM_AW(RAM_AW)) u_ram_aau (.*);

    // Stores take the accumulator low word
    dsp_ram #(.RAM_AW(RAM_AW)) u_ram (
        .din ( acc_dout ),
        .*
    );

    dsp_dau u_dau (.*);

    dsp_pio u_pio (.*);

endmodule

// ==== dsp_pio.sv ====
// Parallel port with the output register and the active-low data strobes
module dsp_pio (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           cen,
    input  logic                           out_strobe,
    input  dsp_dau_pkg::out_half_t         out_half,
    input  logic                           in_strobe,
    input  logic [dsp_dau_pkg::ACC_W-1:0]  acc_full,
    input  logic [dsp_dau_pkg::DATA_W-1:0] pbus_in,
    output logic [dsp_dau_pkg::DATA_W-1:0] pbus_out,
    output logic                           pods_n,
    output logic                           pids_n,
    output logic [dsp_dau_pkg::DATA_W-1:0] pio_din
);
    import dsp_dau_pkg::*;

    logic [DATA_W-1:0] out_sel;
    logic [DATA_W-1:0] out_q;

    assign out_sel = (out_half == HIGH_HALF) ? acc_full[2*DATA_W-1:DATA_W]
                                             : acc_full[DATA_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
        end else if (cen && out_strobe) begin
            out_q <= out_sel;
        end
    end

    // Word shows during the strobe cycle and is held afterwards
    assign pbus_out = out_strobe ? out_sel : out_q;
    assign pods_n   = ~(cen & out_strobe);
    assign pids_n   = ~(cen & in_strobe);
    // Captured by the arithmetic unit at the end of the strobe
    assign pio_din  = pbus_in;

endmodule

// ==== dsp_dau.sv ====
// Data arithmetic unit with x, y and accumulator registers and the multiplier
module dsp_dau (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           cen,
    input  logic [dsp_isa_pkg::OPND_W-1:0] operand,
    input  logic [dsp_dau_pkg::DATA_W-1:0] ram_dout,
    input  logic [dsp_dau_pkg::DATA_W-1:0] pio_din,
    input  logic                           x_imm_load,
    input  logic                           y_imm_load,
    input  logic                           x_ram_load,
    input  logic                           x_pio_load,
    input  logic                           mpy,
    input  logic                           mac,
    input  logic                           acc_clr,
    output logic [dsp_dau_pkg::DATA_W-1:0] acc_dout,
    output logic [dsp_dau_pkg::ACC_W-1:0]  acc_full
);
    import dsp_isa_pkg::*;
    import dsp_dau_pkg::*;

    logic signed [DATA_W-1:0] x;
    logic signed [DATA_W-1:0] y;
    logic signed [ACC_W-1:0]  acc;
    logic        [DATA_W-1:0] imm_ext;
    logic signed [PROD_W-1:0] prod;
    logic signed [ACC_W-1:0]  prod_ext;

    // Immediates are 12-bit two's complement
    assign imm_ext  = {{(DATA_W-OPND_W){operand[OPND_W-1]}}, operand};
    assign prod     = x * y;
    assign prod_ext = {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x   <= '0;
            y   <= '0;
            acc <= '0;
        end else if (cen) begin
            if (x_imm_load) begin
                x <= imm_ext;
            end else if (x_ram_load) begin
                x <= ram_dout;
            end else if (x_pio_load) begin
                x <= pio_din;
            end
            if (y_imm_load) begin
                y <= imm_ext;
            end
            // MAC adds the product of the current x and y
            if (acc_clr) begin
                acc <= '0;
            end else if (mpy) begin
                acc <= prod_ext;
            end else if (mac) begin
                acc <= acc + prod_ext;
            end
        end
    end

    assign acc_dout = acc[DATA_W-1:0];
    assign acc_full = acc;

    a_x_src: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({x_imm_load, x_ram_load, x_pio_load}));

endmodule

// ==== dsp_ram.sv ====
// Data RAM with clocked write and combinational read
module dsp_ram #(
    parameter int RAM_AW = 6
) (
    input  logic                           clk,
    input  logic                           cen,
    input  logic [RAM_AW-1:0]              ram_addr,
    input  logic                           ram_we,
    input  logic [dsp_dau_pkg::DATA_W-1:0] din,
    output logic [dsp_dau_pkg::DATA_W-1:0] ram_dout
);
    import dsp_dau_pkg::*;

    logic [DATA_W-1:0] mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (cen && ram_we) begin
            mem[ram_addr] <= din;
        end
    end

    assign ram_dout = mem[ram_addr];

endmodule

// ==== dsp_ram_aau.sv ====
// Four RAM pointer registers with immediate load and post-increment
module dsp_ram_aau #(
    parameter int RAM_AW = 6
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              cen,
    input  logic                              ptr_load,
    input  logic                              ptr_post,
    input  logic [dsp_isa_pkg::PTR_SEL_W-1:0] ptr_sel,
    input  logic [dsp_isa_pkg::OPND_W-1:0]    operand,
    output logic [RAM_AW-1:0]                 ram_addr
);
    import dsp_isa_pkg::*;

    localparam int NPTR = 2**PTR_SEL_W;

    logic [RAM_AW-1:0] ptr [NPTR];

    // Selected pointer addresses the RAM directly
    assign ram_addr = ptr[ptr_sel];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NPTR; i++) begin
                ptr[i] <= '0;
            end
        end else if (cen) begin
            if (ptr_load) begin
                ptr[ptr_sel] <= RAM_AW'(operand);
            end else if (ptr_post) begin
                // Wraps at the top of the RAM
                ptr[ptr_sel] <= ptr[ptr_sel] + 1'b1;
            end
        end
    end

    a_ptr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(ptr_load && ptr_post));

endmodule

// ==== dsp_rom_aau.sv ====
// Program counter with jump and loop branch, 12-bit loop counter and halt flag
module dsp_rom_aau #(
    parameter int ROM_AW = 8
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           cen,
    input  logic                           pc_inc,
    input  logic                           jump,
    input  logic                           cnt_load,
    input  logic                           djnz,
    input  logic                           halt_set,
    input  logic [dsp_isa_pkg::OPND_W-1:0] operand,
    output logic [ROM_AW-1:0]              pc,
    output logic                           halted
);
    import dsp_isa_pkg::*;

    logic [OPND_W-1:0] cnt;
    logic [OPND_W-1:0] cnt_dec;
    logic [ROM_AW-1:0] target;
    logic              take_loop;

    assign cnt_dec   = cnt - 1'b1;
    assign take_loop = djnz && (cnt_dec != '0);
    assign target    = ROM_AW'(operand);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            cnt    <= '0;
            halted <= 1'b0;
        end else if (cen) begin
            if (jump || take_loop) begin
                pc <= target;
            end else if (pc_inc || djnz) begin
                // Loop exhausted, fall through
                pc <= pc + 1'b1;
            end
            if (cnt_load) begin
                cnt <= operand;
            end else if (djnz) begin
                cnt <= cnt_dec;
            end
            if (halt_set) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== dsp_rom.sv ====
// Program memory with a byte-wide load port and a registered instruction read
module dsp_rom #(
    parameter int ROM_AW = 8
) (
    input  logic                            clk,
    input  logic                            cen,
    input  logic [ROM_AW-1:0]               pc,
    output logic [dsp_isa_pkg::INSTR_W-1:0] instr,
    input  logic [ROM_AW:0]                 prog_addr,
    input  logic [7:0]                      prog_data,
    input  logic                            prog_we
);
    import dsp_isa_pkg::*;

    logic [INSTR_W-1:0] mem [2**ROM_AW];

    // Address bit 0 picks the byte lane; loading ignores cen
    always_ff @(posedge clk) begin
        if (prog_we) begin
            if (prog_addr[0]) begin
                mem[prog_addr[ROM_AW:1]][15:8] <= prog_data;
            end else begin
                mem[prog_addr[ROM_AW:1]][7:0] <= prog_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            instr <= mem[pc];
        end
    end

    // Core must be stopped while the program is loaded
    a_prog_idle: assert property (@(posedge clk) prog_we |-> !cen);

endmodule

// ==== dsp_ctrl.sv ====
// Fetch and execute sequencer with the instruction decoder and all load strobes
module dsp_ctrl (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             cen,
    input  logic [dsp_isa_pkg::INSTR_W-1:0]  instr,
    input  logic                             halted,
    output logic [dsp_isa_pkg::OPND_W-1:0]   operand,
    // ROM address unit
    output logic                             pc_inc,
    output logic                             jump,
    output logic                             cnt_load,
    output logic                             djnz,
    output logic                             halt_set,
    // RAM address unit and RAM
    output logic                             ptr_load,
    output logic                             ptr_post,
    output logic [dsp_isa_pkg::PTR_SEL_W-1:0] ptr_sel,
    output logic                             ram_we,
    // Arithmetic unit
    output logic                             x_imm_load,
    output logic                             y_imm_load,
    output logic                             x_ram_load,
    output logic                             x_pio_load,
    output logic                             mpy,
    output logic                             mac,
    output logic                             acc_clr,
    // Parallel port
    output logic                             out_strobe,
    output dsp_dau_pkg::out_half_t           out_half,
    output logic                             in_strobe
);
    import dsp_isa_pkg::*;
    import dsp_dau_pkg::*;

    typedef enum logic {
        FETCH = 1'b0,
        EXEC  = 1'b1
    } state_t;

    state_t  state;
    opcode_t opc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FETCH;
        end else if (cen) begin
            state <= (state == FETCH) ? EXEC : FETCH;
        end
    end

    assign opc      = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign operand  = instr[OPND_W-1:0];
    assign out_half = out_half_t'(instr[0]);
    assign ptr_sel  = (opc == LDP) ? instr[LDP_SEL_LSB +: PTR_SEL_W]
                                   : instr[IDX_SEL_LSB +: PTR_SEL_W];

    always_comb begin
        pc_inc     = 1'b0;
        jump       = 1'b0;
        cnt_load   = 1'b0;
        djnz       = 1'b0;
        halt_set   = 1'b0;
        ptr_load   = 1'b0;
        ptr_post   = 1'b0;
        ram_we     = 1'b0;
        x_imm_load = 1'b0;
        y_imm_load = 1'b0;
        x_ram_load = 1'b0;
        x_pio_load = 1'b0;
        mpy        = 1'b0;
        mac        = 1'b0;
        acc_clr    = 1'b0;
        out_strobe = 1'b0;
        in_strobe  = 1'b0;
        // Nothing issues after HALT
        if (state == EXEC && !halted) begin
            pc_inc = 1'b1;
            case (opc)
                LDX:  x_imm_load = 1'b1;
                LDY:  y_imm_load = 1'b1;
                LDP:  ptr_load   = 1'b1;
                RDX: begin
                    x_ram_load = 1'b1;
                    ptr_post   = 1'b1;
                end
                WRA: begin
                    ram_we   = 1'b1;
                    ptr_post = 1'b1;
                end
                MPY:  mpy        = 1'b1;
                MAC:  mac        = 1'b1;
                CLRA: acc_clr    = 1'b1;
                OUT:  out_strobe = 1'b1;
                INP: begin
                    x_pio_load = 1'b1;
                    in_strobe  = 1'b1;
                end
                LDC:  cnt_load   = 1'b1;
                // Branches let the address unit pick the next pc
                GOTO: begin
                    pc_inc = 1'b0;
                    jump   = 1'b1;
                end
                DJNZ: begin
                    pc_inc = 1'b0;
                    djnz   = 1'b1;
                end
                HALT: begin
                    pc_inc   = 1'b0;
                    halt_set = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Port strobes share the bus cycle and must not overlap
    a_pio_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(out_strobe && in_strobe));

endmodule

// ==== dsp_dau_pkg.sv ====
// Data path widths and the accumulator half select used by the output port
package dsp_dau_pkg;

    localparam int DATA_W = 16;
    localparam int PROD_W = 2 * DATA_W;
    // Four guard bits above the product
    localparam int ACC_W  = PROD_W + 4;

    typedef enum logic {
        LOW_HALF  = 1'b0,
        HIGH_HALF = 1'b1
    } out_half_t;

endpackage

// ==== dsp_isa_pkg.sv ====
// Instruction word layout, field positions and the opcode encoding
package dsp_isa_pkg;

    localparam int INSTR_W   = 16;
    localparam int OPC_W     = 4;
    localparam int OPND_W    = 12;
    localparam int OPC_LSB   = INSTR_W - OPC_W;
    localparam int PTR_SEL_W = 2;

    // Pointer select sits high in the operand for LDP, low for RDX and WRA
    localparam int LDP_SEL_LSB = OPND_W - PTR_SEL_W;
    localparam int IDX_SEL_LSB = 0;

    // Code 15 is unassigned and executes as a NOP
    typedef enum logic [OPC_W-1:0] {
        NOP  = 4'd0,
        LDX  = 4'd1,
        LDY  = 4'd2,
        LDP  = 4'd3,
        RDX  = 4'd4,
        WRA  = 4'd5,
        MPY  = 4'd6,
        MAC  = 4'd7,
        CLRA = 4'd8,
        OUT  = 4'd9,
        INP  = 4'd10,
        GOTO = 4'd11,
        LDC  = 4'd12,
        DJNZ = 4'd13,
        HALT = 4'd14
    } opcode_t;

endpackage
